// ==== fpm_defines.svh ====
`ifndef FPM_DEFINES_SVH
`define FPM_DEFINES_SVH

// Binary32 field widths
`define FPM_EXP_W   8
`define FPM_FRAC_W  23

// Exponent bias of the single format
`define FPM_BIAS    127

// APB address width in bits
`define FPM_APB_AW  8

// Register byte offsets
`define FPM_REG_X     8'h00
`define FPM_REG_Y     8'h04
`define FPM_REG_MODE  8'h08
`define FPM_REG_CTRL  8'h0C
// Read only, a write gets pslverr
`define FPM_REG_STAT  8'h10
`define FPM_REG_Z     8'h14

`endif

// ==== fpm_pkg.sv ====
`include "fpm_defines.svh"

package fpm_pkg;

    // Field view of a binary32 word
    typedef struct packed {
        logic                   sign;
        logic [`FPM_EXP_W-1:0]  exp;
        logic [`FPM_FRAC_W-1:0] frac;
    } fp32_fields_s;

    // Same word seen raw on the bus or split into fields by the core
    typedef union packed {
        logic [`FPM_EXP_W+`FPM_FRAC_W:0] raw;
        fp32_fields_s                    f;
    } fp32_u;

    // Rounding modes, codes 5 to 7 fall back to nearest-even
    typedef enum logic [2:0] {
        rne = 3'd0,
        rtz = 3'd1,
        rdn = 3'd2,
        rup = 3'd3,
        rmm = 3'd4
    } rmode_e;

    // Operand class, subnormals count as zero
    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
    } fp_class_s;

    // Result flags
    typedef struct packed {
        logic ovrf;
        logic udrf;
        logic zer;
        logic inf;
        logic nan;
    } fpm_flags_s;

    // Full significand product
    typedef struct packed {
        logic [2*`FPM_FRAC_W+1:0] full;
    } mant_prod_s;

    // Leading one, fraction, guard, round and sticky
    typedef struct packed {
        logic [`FPM_FRAC_W+3:0] sig;
        logic                   norm_n;
    } norm_out_s;

    typedef struct packed {
        logic [`FPM_FRAC_W-1:0] frac;
        logic                   norm_r;
        logic                   inexact;
    } round_out_s;

endpackage

// ==== fpm_apb_pkg.sv ====
`include "fpm_defines.svh"

package fpm_apb_pkg;

    // Master to slave
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`FPM_APB_AW-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_s;

    // Slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_s;

    // CTRL layout, bit 0 starts a multiply
    typedef struct packed {
        logic [30:0] rsvd;
        logic        start;
    } ctrl_reg_s;

    // STATUS layout, flags in bits 5 to 1 and done in bit 0
    typedef struct packed {
        logic [25:0]         rsvd;
        fpm_pkg::fpm_flags_s flags;
        logic                done;
    } stat_reg_s;

endpackage

// ==== fpm_booth_mul.sv ====
`timescale 1ns/1ps
`include "fpm_defines.svh"

module fpm_booth_mul (
    input  logic [`FPM_FRAC_W:0] sig_a,
    input  logic [`FPM_FRAC_W:0] sig_b,
    output fpm_pkg::mant_prod_s  prod
);

    localparam int SIG_W  = `FPM_FRAC_W + 1;
    // Radix-4 digits needed to cover the unsigned multiplier
    localparam int NDIG   = (SIG_W + 2) / 2;
    // Room for 2A plus a sign bit
    localparam int PP_W   = SIG_W + 3;
    localparam int PROD_W = 2 * SIG_W;

    // Multiplier with a zero below bit 0 and zero extension on top
    logic [2*NDIG:0]   b_ext;
    logic [PP_W-1:0]   a_pos;
    logic [PP_W-1:0]   a_dbl;
    logic [PP_W-1:0]   pp [NDIG];
    logic [PROD_W-1:0] acc;

    assign b_ext = {{(2*NDIG-SIG_W){1'b0}}, sig_b, 1'b0};
    assign a_pos = {{(PP_W-SIG_W){1'b0}}, sig_a};
    assign a_dbl = {{(PP_W-SIG_W-1){1'b0}}, sig_a, 1'b0};

    // Booth recoding, each overlapping triplet picks 0, +-A or +-2A
    always_comb begin
        for (int i = 0; i < NDIG; i++) begin
            case (b_ext[2*i+2 -: 3])
                3'b001,
                3'b010:  pp[i] = a_pos;
                3'b011:  pp[i] = a_dbl;
                3'b100:  pp[i] = ~a_dbl + 1'b1;
                3'b101,
                3'b110:  pp[i] = ~a_pos + 1'b1;
                // 000 and 111
                default: pp[i] = '0;
            endcase
        end
    end

    // Sign extend and weight each partial product by 4^i
    // Sum wraps modulo 2^48, the true product always fits
    always_comb begin
        acc = '0;
        for (int i = 0; i < NDIG; i++) begin
            acc = acc + ({{(PROD_W-PP_W){pp[i][PP_W-1]}}, pp[i]} << (2*i));
        end
    end

    assign prod.full = acc;

endmodule

// ==== fpm_norm_round.sv ====
`timescale 1ns/1ps
`include "fpm_defines.svh"

module fpm_norm_round (
    input  fpm_pkg::mant_prod_s prod,
    input  fpm_pkg::rmode_e     mode,
    input  logic                sign,
    output fpm_pkg::norm_out_s  norm,
    output fpm_pkg::round_out_s rnd
);

    import fpm_pkg::*;

    localparam int PROD_W = 2 * (`FPM_FRAC_W + 1);
    // Leading one, fraction, guard and round
    localparam int KEEP_W = `FPM_FRAC_W + 3;

    logic [PROD_W-1:0]      shifted;
    logic [KEEP_W:0]        sig;
    logic [`FPM_FRAC_W-1:0] frac;
    logic                   guard;
    logic                   round_bit;
    logic                   sticky;
    logic                   inexact;
    logic                   inc;
    logic [`FPM_FRAC_W:0]   sum;

    // Product of two values in [1,2) lies in [1,4)
    // Top bit set means the product reached 2.0
    assign shifted = prod.full[PROD_W-1] ? prod.full
                                         : {prod.full[PROD_W-2:0], 1'b0};

    // Low bits collapse into sticky
    assign sig = {shifted[PROD_W-1 -: KEEP_W], |shifted[PROD_W-KEEP_W-1:0]};

    assign norm.sig    = sig;
    assign norm.norm_n = prod.full[PROD_W-1];

    assign frac      = sig[KEEP_W-1:3];
    assign guard     = sig[2];
    assign round_bit = sig[1];
    assign sticky    = sig[0];
    assign inexact   = guard | round_bit | sticky;

    // Increment decision per rounding mode
    always_comb begin
        case (mode)
            rtz:     inc = 1'b0;
            // Toward minus infinity, only negatives grow in magnitude
            rdn:     inc = inexact & sign;
            rup:     inc = inexact & ~sign;
            // Ties away from zero
            rmm:     inc = guard;
            // Nearest-even, also for unused codes
            default: inc = guard & (round_bit | sticky | frac[0]);
        endcase
    end

    // Extra bit catches 1.111..1 rounding up to 10.000..0
    assign sum = {1'b0, frac} + {{`FPM_FRAC_W{1'b0}}, inc};

    // On carry the fraction wraps to zero and the exponent takes the bump
    assign rnd.frac    = sum[`FPM_FRAC_W-1:0];
    assign rnd.norm_r  = sum[`FPM_FRAC_W];
    assign rnd.inexact = inexact;

endmodule

// ==== fpm_exp_exc.sv ====
`timescale 1ns/1ps
`include "fpm_defines.svh"

module fpm_exp_exc (
    input  fpm_pkg::fp32_u       op_x,
    input  fpm_pkg::fp32_u       op_y,
    input  fpm_pkg::rmode_e      mode,
    output logic [`FPM_FRAC_W:0] sig_x,
    output logic [`FPM_FRAC_W:0] sig_y,
    output logic                 sign,
    input  fpm_pkg::norm_out_s   norm,
    input  fpm_pkg::round_out_s  rnd,
    output fpm_pkg::fp32_u       result,
    output fpm_pkg::fpm_flags_s  flags
);

    import fpm_pkg::*;

    localparam logic [`FPM_EXP_W-1:0] EXP_MAX = '1;
    // Two guard bits, one for the carry and one for the sign
    localparam int EXP_SUM_W = `FPM_EXP_W + 2;

    fp_class_s                   cls_x;
    fp_class_s                   cls_y;
    logic signed [EXP_SUM_W-1:0] exp_biased;
    logic                        exp_udrf;
    logic                        exp_ovrf;
    logic                        sat_max;
    logic                        any_nan;
    logic                        any_inf;
    logic                        any_zero;

    // Exponent 0 covers both zero and subnormal
    function automatic fp_class_s classify(input fp32_u op);
        fp_class_s c;
        c.is_zero = (op.f.exp == '0);
        c.is_inf  = (op.f.exp == EXP_MAX) && (op.f.frac == '0);
        c.is_nan  = (op.f.exp == EXP_MAX) && (op.f.frac != '0);
        return c;
    endfunction

    assign cls_x = classify(op_x);
    assign cls_y = classify(op_y);

    // Hidden bit dropped for zero and subnormal operands
    assign sig_x = {~cls_x.is_zero, op_x.f.frac};
    assign sig_y = {~cls_y.is_zero, op_y.f.frac};
    assign sign  = op_x.f.sign ^ op_y.f.sign;

    // Rebias and add the normalization and rounding carries
    assign exp_biased = signed'({2'b00, op_x.f.exp} + {2'b00, op_y.f.exp}
                                + EXP_SUM_W'(norm.norm_n) + EXP_SUM_W'(rnd.norm_r)
                                - EXP_SUM_W'(`FPM_BIAS));

    assign exp_udrf = (exp_biased <= 0);
    assign exp_ovrf = (exp_biased >= 255);

    // Modes that never round up to infinity for this sign
    assign sat_max = (mode == rtz) || ((mode == rdn) && !sign) || ((mode == rup) && sign);

    // Inf times zero is invalid just like a NaN input
    assign any_nan  = cls_x.is_nan | cls_y.is_nan | (cls_x.is_inf & cls_y.is_zero)
                    | (cls_y.is_inf & cls_x.is_zero);
    assign any_inf  = cls_x.is_inf | cls_y.is_inf;
    assign any_zero = cls_x.is_zero | cls_y.is_zero;

    // Special cases in priority order, normal packing last
    always_comb begin
        flags         = '0;
        result.f.sign = sign;
        result.f.exp  = exp_biased[`FPM_EXP_W-1:0];
        result.f.frac = rnd.frac;
        if (any_nan) begin
            // Canonical quiet NaN 0x7FC00000
            result.f.sign = 1'b0;
            result.f.exp  = EXP_MAX;
            result.f.frac = {1'b1, {(`FPM_FRAC_W-1){1'b0}}};
            flags.nan     = 1'b1;
        end else if (any_inf) begin
            result.f.exp  = EXP_MAX;
            result.f.frac = '0;
            flags.inf     = 1'b1;
        end else if (any_zero || exp_udrf) begin
            // Flush to signed zero
            result.f.exp  = '0;
            result.f.frac = '0;
            flags.zer     = 1'b1;
            flags.udrf    = ~any_zero;
        end else if (exp_ovrf) begin
            flags.ovrf    = 1'b1;
            flags.inf     = 1'b1;
            result.f.exp  = sat_max ? EXP_MAX - 1'b1 : EXP_MAX;
            result.f.frac = sat_max ? '1 : '0;
        end
    end

endmodule

// ==== fpm_apb_regs.sv ====
`timescale 1ns/1ps
`include "fpm_defines.svh"

module fpm_apb_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  fpm_apb_pkg::apb_req_s req,
    output fpm_apb_pkg::apb_rsp_s rsp,
    output fpm_pkg::fp32_u        op_x,
    output fpm_pkg::fp32_u        op_y,
    output fpm_pkg::rmode_e       mode,
    input  fpm_pkg::fp32_u        result,
    input  fpm_pkg::fpm_flags_s   flags
);

    import fpm_pkg::*;
    import fpm_apb_pkg::*;

    logic      access;
    logic      wr_en;
    logic      rd_en;
    logic      hit;
    logic      ro_hit;
    ctrl_reg_s ctrl_wr;
    logic      capture;
    fp32_u     reg_z;
    stat_reg_s stat;

    // Second cycle of a transfer, pready is always high
    assign access  = req.psel & req.penable;
    assign wr_en   = access & req.pwrite;
    assign rd_en   = access & ~req.pwrite;
    assign ctrl_wr = ctrl_reg_s'(req.pwdata);

    // Address decode
    always_comb begin
        hit    = 1'b1;
        ro_hit = 1'b0;
        case (req.paddr)
            `FPM_REG_X,
            `FPM_REG_Y,
            `FPM_REG_MODE,
            `FPM_REG_CTRL: ro_hit = 1'b0;
            `FPM_REG_STAT,
            `FPM_REG_Z:    ro_hit = 1'b1;
            default:       hit    = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_x    <= '0;
            op_y    <= '0;
            mode    <= rne;
            capture <= 1'b0;
            reg_z   <= '0;
            stat    <= '0;
        end else begin
            // Strobe lasts one cycle
            capture <= 1'b0;
            if (wr_en) begin
                case (req.paddr)
                    `FPM_REG_X:    op_x.raw <= req.pwdata;
                    `FPM_REG_Y:    op_y.raw <= req.pwdata;
                    `FPM_REG_MODE: mode     <= rmode_e'(req.pwdata[2:0]);
                    `FPM_REG_CTRL: begin
                        if (ctrl_wr.start) begin
                            capture   <= 1'b1;
                            stat.done <= 1'b0;
                        end
                    end
                    // Writes to STATUS, Z or unmapped offsets are dropped
                    default: ;
                endcase
            end
            // Core has settled on the operands by now
            if (capture) begin
                reg_z      <= result;
                stat.flags <= flags;
                stat.done  <= 1'b1;
            end
        end
    end

    // Zero wait state read path
    always_comb begin
        rsp.pready  = 1'b1;
        rsp.pslverr = access & (~hit | (req.pwrite & ro_hit));
        rsp.prdata  = '0;
        if (rd_en) begin
            case (req.paddr)
                `FPM_REG_X:    rsp.prdata = op_x.raw;
                `FPM_REG_Y:    rsp.prdata = op_y.raw;
                `FPM_REG_MODE: rsp.prdata = {{(32-$bits(rmode_e)){1'b0}}, mode};
                `FPM_REG_STAT: rsp.prdata = stat;
                `FPM_REG_Z:    rsp.prdata = reg_z.raw;
                // CTRL reads as zero
                default:       rsp.prdata = '0;
            endcase
        end
    end

endmodule

// ==== fpm_top.sv ====
`timescale 1ns/1ps
`include "fpm_defines.svh"

module fpm_top (
    input  logic                  clk,
    input  logic                  rst,
    input  fpm_apb_pkg::apb_req_s req,
    output fpm_apb_pkg::apb_rsp_s rsp
);

    import fpm_pkg::*;

    // Register outputs feeding the core
    fp32_u                op_x;
    fp32_u                op_y;
    rmode_e               mode;
    // Core results back to the register block
    fp32_u                result;
    fpm_flags_s           flags;
    // Internal datapath
    logic [`FPM_FRAC_W:0] sig_x;
    logic [`FPM_FRAC_W:0] sig_y;
    logic                 sign;
    mant_prod_s           prod;
    norm_out_s            norm;
    round_out_s           rnd;

    fpm_apb_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .rsp    (rsp),
        .op_x   (op_x),
        .op_y   (op_y),
        .mode   (mode),
        .result (result),
        .flags  (flags)
    );

    // Classification and significands on the way in, packing on the way out
    fpm_exp_exc u_exp_exc (
        .op_x   (op_x),
        .op_y   (op_y),
        .mode   (mode),
        .sig_x  (sig_x),
        .sig_y  (sig_y),
        .sign   (sign),
        .norm   (norm),
        .rnd    (rnd),
        .result (result),
        .flags  (flags)
    );

    fpm_booth_mul u_booth (
        .sig_a (sig_x),
        .sig_b (sig_y),
        .prod  (prod)
    );

    fpm_norm_round u_norm_round (
        .prod (prod),
        .mode (mode),
        .sign (sign),
        .norm (norm),
        .rnd  (rnd)
    );

endmodule

// ==== fpm_tb_clkgen.sv ====
`timescale 1ns/1ps

module fpm_tb_clkgen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held over three rising edges, released on the third
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== fpm_tb_checker.sv ====
`timescale 1ns/1ps

module fpm_tb_checker (
    input logic                  clk,
    input fpm_apb_pkg::apb_req_s req,
    input fpm_apb_pkg::apb_rsp_s rsp
);

    // One expected bus transfer
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] mask;
        logic        err;
        logic        last;
    } xfer_exp_s;

    xfer_exp_s exp_q[$];
    string     name_q[$];
    int        n_tests  = 0;
    int        n_failed = 0;
    int        n_checks = 0;
    int        n_errors = 0;
    bit        test_bad = 1'b0;

    // Queued by the testbench just before the transfer it describes
    task automatic expect_xfer(input logic [7:0] addr, input logic [31:0] data,
                               input logic [31:0] mask, input logic err,
                               input string name, input logic last);
        xfer_exp_s e;
        e.addr = addr;
        e.data = data;
        e.mask = mask;
        e.err  = err;
        e.last = last;
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // Mid access cycle, request and read data have settled
    always @(negedge clk) begin : compare
        xfer_exp_s e;
        string     name;
        if (req.psel && req.penable && rsp.pready && exp_q.size() > 0) begin
            e    = exp_q.pop_front();
            name = name_q.pop_front();
            n_checks++;
            if (req.paddr != e.addr) begin
                $display("Fail @ %0t: %s: transfer at 0x%02h, expected 0x%02h",
                         $time, name, req.paddr, e.addr);
                n_errors++;
                test_bad = 1'b1;
            end
            // Mask is zero for writes
            if ((rsp.prdata & e.mask) != (e.data & e.mask)) begin
                $display("Fail @ %0t: %s: read 0x%02h gave 0x%08h, expected 0x%08h",
                         $time, name, req.paddr, rsp.prdata & e.mask, e.data & e.mask);
                n_errors++;
                test_bad = 1'b1;
            end
            if (rsp.pslverr != e.err) begin
                $display("Fail @ %0t: %s: pslverr %b at 0x%02h, expected %b",
                         $time, name, rsp.pslverr, req.paddr, e.err);
                n_errors++;
                test_bad = 1'b1;
            end
            // Last transfer of a test closes it
            if (e.last) begin
                $display("%0t  %s: %s", $time, name, test_bad ? "FAIL" : "pass");
                n_tests++;
                if (test_bad) n_failed++;
                test_bad = 1'b0;
            end
        end
    end

endmodule

// ==== fpm_properties.sv ====
`timescale 1ns/1ps
`include "fpm_defines.svh"

module fpm_properties (
    input logic                   clk,
    input logic                   rst,
    input fpm_pkg::fp32_u         op_x,
    input fpm_pkg::fp32_u         op_y,
    input fpm_pkg::fp32_u         result,
    input fpm_pkg::norm_out_s     norm,
    input fpm_pkg::fpm_flags_s    flags,
    input fpm_apb_pkg::stat_reg_s stat
);

    import fpm_pkg::*;

    // Number of failed assertions
    int fail_count = 0;

    logic x_fin_nz;
    logic y_fin_nz;

    // Nonzero finite means exponent neither all zeros nor all ones
    assign x_fin_nz = (op_x.f.exp != '0) && (op_x.f.exp != '1);
    assign y_fin_nz = (op_y.f.exp != '0) && (op_y.f.exp != '1);

    // Packed result keeps the product sign, only the canonical NaN is forced positive
    sign_is_xor: assert property (@(posedge clk) disable iff (rst)
        !flags.nan |-> (result.f.sign == (op_x.f.sign ^ op_y.f.sign)))
        else begin
            fail_count++;
            $error("result sign differs from XOR of operand signs");
        end

    // Product of two values in [1,2) keeps its leading one after normalization
    lead_one: assert property (@(posedge clk) disable iff (rst)
        (x_fin_nz && y_fin_nz) |-> norm.sig[`FPM_FRAC_W+3])
        else begin
            fail_count++;
            $error("normalized significand lost its leading one");
        end

    special_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({flags.zer, flags.inf, flags.nan}))
        else begin
            fail_count++;
            $error("more than one of zer, inf and nan set");
        end

    udrf_zer: assert property (@(posedge clk) disable iff (rst)
        flags.udrf |-> flags.zer)
        else begin
            fail_count++;
            $error("udrf without zer");
        end

    ovrf_inf: assert property (@(posedge clk) disable iff (rst)
        flags.ovrf |-> flags.inf)
        else begin
            fail_count++;
            $error("ovrf without inf");
        end

    done_after_rst: assert property (@(posedge clk) $fell(rst) |-> !stat.done)
        else begin
            fail_count++;
            $error("done high right after reset release");
        end

endmodule

bind fpm_top fpm_properties u_props (
    .clk    (clk),
    .rst    (rst),
    .op_x   (op_x),
    .op_y   (op_y),
    .result (result),
    .norm   (norm),
    .flags  (flags),
    .stat   (u_regs.stat)
);

// ==== fpm_tb.sv ====
`timescale 1ns/1ps
`include "fpm_defines.svh"

module fpm_tb;

    import fpm_pkg::*;
    import fpm_apb_pkg::*;

    // Bound on every wait loop, in cycles or polls
    localparam int WAIT_MAX = 50;

    // Expected product and flags of one multiply
    typedef struct packed {
        logic [31:0] z;
        fpm_flags_s  flags;
    } ref_res_s;

    logic     clk;
    logic     rst;
    apb_req_s req;
    apb_rsp_s rsp;
    int       seed;
    bit       hung;

    fpm_tb_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    fpm_top DUT (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    fpm_tb_checker u_chk (
        .clk (clk),
        .req (req),
        .rsp (rsp)
    );

    // Subnormals count as zero
    function automatic fp_class_s class_of(input logic [31:0] w);
        fp_class_s c;
        c.is_zero = (w[30:23] == 8'h00);
        c.is_inf  = (w[30:23] == 8'hFF) && (w[22:0] == '0);
        c.is_nan  = (w[30:23] == 8'hFF) && (w[22:0] != '0);
        return c;
    endfunction

    // Binary32 product with flush to zero, worked out on integers
    function automatic ref_res_s fpm_ref_mul(input logic [31:0] x, input logic [31:0] y,
                                             input logic [2:0] m);
        ref_res_s    r;
        fp_class_s   cx;
        fp_class_s   cy;
        logic        s;
        int          e;
        int          drop;
        logic [47:0] p;
        logic [47:0] rem;
        logic [47:0] half;
        logic [24:0] sig;
        logic        up;
        logic        sat;
        cx   = class_of(x);
        cy   = class_of(y);
        s    = x[31] ^ y[31];
        p    = {24'd0, 1'b1, x[22:0]} * {24'd0, 1'b1, y[22:0]};
        // Product in [2,4) drops one more bit and bumps the exponent
        drop = p[47] ? 24 : 23;
        e    = int'(x[30:23]) + int'(y[30:23]) - `FPM_BIAS + (p[47] ? 1 : 0);
        sig  = 25'(p >> drop);
        rem  = p & ((48'd1 << drop) - 48'd1);
        half = 48'd1 << (drop - 1);
        case (m)
            3'd1:    up = 1'b0;
            3'd2:    up = (rem != '0) && s;
            3'd3:    up = (rem != '0) && !s;
            3'd4:    up = (rem >= half);
            default: up = (rem > half) || ((rem == half) && sig[0]);
        endcase
        sig = sig + 25'(up);
        // Rounding up to 2.0 renormalizes
        if (sig[24]) begin
            sig = sig >> 1;
            e   = e + 1;
        end
        sat     = (m == 3'd1) || ((m == 3'd2) && !s) || ((m == 3'd3) && s);
        r.flags = '0;
        if (cx.is_nan || cy.is_nan || (cx.is_inf && cy.is_zero) || (cy.is_inf && cx.is_zero)) begin
            r.z         = 32'h7FC00000;
            r.flags.nan = 1'b1;
        end else if (cx.is_inf || cy.is_inf) begin
            r.z         = {s, 8'hFF, 23'd0};
            r.flags.inf = 1'b1;
        end else if (cx.is_zero || cy.is_zero) begin
            r.z         = {s, 31'd0};
            r.flags.zer = 1'b1;
        end else if (e <= 0) begin
            r.z          = {s, 31'd0};
            r.flags.zer  = 1'b1;
            r.flags.udrf = 1'b1;
        end else if (e >= 255) begin
            r.z          = sat ? {s, 8'hFE, 23'h7FFFFF} : {s, 8'hFF, 23'd0};
            r.flags.ovrf = 1'b1;
            r.flags.inf  = 1'b1;
        end else begin
            r.z = {s, 8'(e), sig[22:0]};
        end
        return r;
    endfunction

    // Setup then access, read data taken mid access cycle
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int waits;
        waits = 0;
        @(posedge clk);
        req.psel    <= 1'b1;
        req.penable <= 1'b0;
        req.pwrite  <= wr;
        req.paddr   <= addr;
        req.pwdata  <= wdata;
        @(posedge clk);
        req.penable <= 1'b1;
        @(negedge clk);
        while (!rsp.pready && waits < WAIT_MAX) begin
            @(negedge clk);
            waits++;
        end
        if (!rsp.pready) begin
            $display("Timeout: pready stayed low in transfer to 0x%02h", addr);
            hung = 1'b1;
        end
        rdata = rsp.prdata;
        @(posedge clk);
        req <= '0;
    endtask

    // Transfer whose response the checker compares
    task automatic check_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              input logic [31:0] exp_data, input logic [31:0] mask,
                              input logic err, input string name, input logic last);
        logic [31:0] rd;
        if (hung) return;
        u_chk.expect_xfer(addr, exp_data, mask, err, name, last);
        apb_xfer(wr, addr, wdata, rd);
    endtask

    // Full multiply, start, wait for done, then check STATUS and Z
    task automatic run_mul(input string name, input logic [31:0] x, input logic [31:0] y,
                           input logic [2:0] m);
        ref_res_s    exp_r;
        logic [31:0] rd;
        int          polls;
        if (hung) return;
        exp_r = fpm_ref_mul(x, y, m);
        apb_xfer(1'b1, `FPM_REG_X, x, rd);
        apb_xfer(1'b1, `FPM_REG_Y, y, rd);
        apb_xfer(1'b1, `FPM_REG_MODE, {29'd0, m}, rd);
        apb_xfer(1'b1, `FPM_REG_CTRL, 32'd1, rd);
        rd    = '0;
        polls = 0;
        while (!rd[0] && polls < WAIT_MAX) begin
            apb_xfer(1'b0, `FPM_REG_STAT, '0, rd);
            polls++;
        end
        if (!rd[0]) begin
            $display("Timeout: STATUS.done never set in %s", name);
            hung = 1'b1;
            return;
        end
        check_xfer(1'b0, `FPM_REG_STAT, '0, {26'd0, exp_r.flags, 1'b1}, '1, 1'b0, name, 1'b0);
        check_xfer(1'b0, `FPM_REG_Z, '0, exp_r.z, '1, 1'b0, name, 1'b1);
    endtask

    initial begin
        int          n;
        logic [31:0] x;
        logic [31:0] y;
        logic [2:0]  m;
        req  = '0;
        seed = 14;
        hung = 1'b0;
        n    = 0;
        while (rst !== 1'b0 && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset never released");
            hung = 1'b1;
        end

        check_xfer(1'b0, `FPM_REG_STAT, '0, '0, '1, 1'b0, "status_after_reset", 1'b1);

        check_xfer(1'b1, `FPM_REG_X, 32'h3F800000, '0, '0, 1'b0, "reg_readback", 1'b0);
        check_xfer(1'b1, `FPM_REG_Y, 32'hC0490FDB, '0, '0, 1'b0, "reg_readback", 1'b0);
        check_xfer(1'b1, `FPM_REG_MODE, 32'd3, '0, '0, 1'b0, "reg_readback", 1'b0);
        check_xfer(1'b0, `FPM_REG_X, '0, 32'h3F800000, '1, 1'b0, "reg_readback", 1'b0);
        check_xfer(1'b0, `FPM_REG_Y, '0, 32'hC0490FDB, '1, 1'b0, "reg_readback", 1'b0);
        check_xfer(1'b0, `FPM_REG_MODE, '0, 32'd3, '1, 1'b0, "reg_readback", 1'b1);

        check_xfer(1'b1, `FPM_REG_Z, 32'hDEADBEEF, '0, '0, 1'b1, "slverr", 1'b0);
        check_xfer(1'b1, `FPM_REG_STAT, 32'h1, '0, '0, 1'b1, "slverr", 1'b0);
        check_xfer(1'b0, 8'h18, '0, '0, '0, 1'b1, "slverr", 1'b0);
        check_xfer(1'b1, 8'h40, 32'h1, '0, '0, 1'b1, "slverr", 1'b0);
        // Rejected write leaves Z at its reset value
        check_xfer(1'b0, `FPM_REG_Z, '0, '0, '1, 1'b0, "slverr", 1'b1);

        // Normal products in every mode, sqrt2 squared carries under rup and rdn
        run_mul("three_by_three_rtz", 32'h40400000, 32'h40400000, 3'd1);
        for (int k = 0; k < 5; k++) begin
            run_mul($sformatf("sqrt2_pos_m%0d", k), 32'h3FB504F3, 32'h3FB504F3, 3'(k));
            run_mul($sformatf("sqrt2_neg_m%0d", k), 32'hBFB504F3, 32'h3FB504F3, 3'(k));
            run_mul($sformatf("near_one_m%0d", k), 32'h3F8CCCCD, 32'hBF8CCCCD, 3'(k));
            run_mul($sformatf("ovf_pos_m%0d", k), 32'h7F000000, 32'h7F000000, 3'(k));
            run_mul($sformatf("ovf_neg_m%0d", k), 32'hFF000000, 32'h7F000000, 3'(k));
        end
        run_mul("mode_code_6", 32'h3F8CCCCD, 32'h3F8CCCCD, 3'd6);

        // Zero and subnormal operands over all sign pairs
        for (int k = 0; k < 4; k++) begin
            run_mul($sformatf("zero_lhs_s%0d", k), {k[0], 31'd0}, {k[1], 8'h85, 23'h123456},
                    3'd0);
            run_mul($sformatf("subn_lhs_s%0d", k), {k[0], 8'h00, 23'h0ABCDE},
                    {k[1], 8'h40, 23'h7FFFFF}, 3'd1);
            run_mul($sformatf("zero_rhs_s%0d", k), {k[0], 8'h7E, 23'h2AAAAA}, {k[1], 31'd0},
                    3'd3);
        end

        run_mul("inf_by_fin", 32'h7F800000, 32'hC0000000, 3'd0);
        run_mul("fin_by_ninf", 32'h3F800000, 32'hFF800000, 3'd2);
        run_mul("inf_by_inf", 32'hFF800000, 32'hFF800000, 3'd0);
        run_mul("inf_by_zero", 32'h7F800000, 32'h80000000, 3'd0);
        run_mul("subn_by_inf", 32'h00000001, 32'h7F800000, 3'd0);
        run_mul("qnan_lhs", 32'h7FC00001, 32'h3F800000, 3'd0);
        run_mul("snan_rhs", 32'h40000000, 32'hFF800001, 3'd4);
        run_mul("nan_by_inf", 32'h7F812345, 32'h7F800000, 3'd0);

        run_mul("udrf_pair", 32'h20000000, 32'h1F800000, 3'd0);
        run_mul("udrf_neg", 32'hA0000000, 32'h1F000000, 3'd3);
        run_mul("min_normal", 32'h20800000, 32'h1F800000, 3'd0);

        // Random normals, exponents 64 to 191 so extremes show up now and then
        for (int k = 0; k < 40; k++) begin
            x          = $random(seed);
            y          = $random(seed);
            x[30:23]   = 8'd64 + (x[30:23] & 8'h7F);
            y[30:23]   = 8'd64 + (y[30:23] & 8'h7F);
            m          = 3'($unsigned($random(seed)) % 5);
            run_mul($sformatf("rand_%0d_m%0d", k, m), x, y, m);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertions %0d, timeouts %0d",
                 u_chk.n_tests, u_chk.n_failed, u_chk.n_checks, u_chk.n_errors,
                 DUT.u_props.fail_count, hung);
        if (!hung && u_chk.n_errors == 0 && u_chk.pending() == 0
                && DUT.u_props.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== fpm.f ====
+incdir+.
fpm_pkg.sv
fpm_apb_pkg.sv
fpm_booth_mul.sv
fpm_norm_round.sv
fpm_exp_exc.sv
fpm_apb_regs.sv
fpm_top.sv
fpm_tb_clkgen.sv
fpm_tb_checker.sv
fpm_properties.sv
fpm_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module fpm_tb -f fpm.f

sim:
	verilator --binary --timing --assert --top-module fpm_tb -f fpm.f -o fpm_sim
	./obj_dir/fpm_sim | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
